// File: rx_pkg.sv
`default_nettype none

package rx_pkg;

  // ----------------------------------------
  // Sizes and bit timing
  // ----------------------------------------
  localparam int NUM_LANES  = 4;
  localparam int BIT_TICKS  = 87;
  localparam int HALF_TICKS = BIT_TICKS / 2;
  localparam int DATA_BITS  = 8;
  localparam int TICK_W     = $clog2(BIT_TICKS + 1);
  localparam int IDX_W      = $clog2(DATA_BITS);

  // Receive FIFO
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;
  localparam int CNT_W      = FIFO_AW + 1;

  // ----------------------------------------
  // Wishbone and register map
  // ----------------------------------------
  localparam int WB_AW = 4;
  localparam int WB_DW = 32;

  localparam logic [WB_AW-1:0] ADDR_CTRL   = 4'h0;
  localparam logic [WB_AW-1:0] ADDR_STATUS = 4'h4;
  localparam logic [WB_AW-1:0] ADDR_RXDATA = 4'h8;

  typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;

  // Synchronized line level plus falling-edge strobe
  typedef struct packed {
    logic level;
    logic fall;
  } line_t;

  typedef struct packed {
    logic                 frame_err;
    logic [DATA_BITS-1:0] data;
  } rx_byte_t;

  // Also the low bits of RXDATA
  typedef struct packed {
    logic      valid;
    lane_idx_t lane;
    rx_byte_t  rx;
  } rx_entry_t;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic [CNT_W-1:0]     count;
    logic [NUM_LANES-1:0] overrun;
  } rx_status_t;

endpackage

`default_nettype wire

// File: line_sync.sv
`timescale 1ns/100ps
`default_nettype none

module line_sync (
  input  wire logic                                      clk,
  input  wire logic                                      rst_n,
  input  wire logic          [rx_pkg::NUM_LANES-1:0]     rx_lines,
  output rx_pkg::line_t      [rx_pkg::NUM_LANES-1:0]     lines
);

  logic [rx_pkg::NUM_LANES-1:0] sync_q1;
  logic [rx_pkg::NUM_LANES-1:0] sync_q2;
  logic [rx_pkg::NUM_LANES-1:0] prev_q;

  // Idle line level is high, so every stage resets to one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '1;
      sync_q2 <= '1;
      prev_q  <= '1;
    end else begin
      sync_q1 <= rx_lines;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
    end
  end

  // Fall strobe lines up with the first low level cycle
  always_comb begin
    for (int i = 0; i < rx_pkg::NUM_LANES; i++) begin
      lines[i].level = sync_q2[i];
      lines[i].fall  = prev_q[i] & ~sync_q2[i];
    end
  end

endmodule

`default_nettype wire

// File: uart_rx_lane.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_lane (
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  rx_pkg::line_t     line,
  input  wire logic         enable,
  input  wire logic         hold_take,
  input  wire logic         overrun_clr,
  output logic              hold_valid,
  output rx_pkg::rx_byte_t  hold_byte,
  output logic              overrun
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } state_e;

  state_e                          state_q;
  logic [rx_pkg::TICK_W-1:0]       tick_q;
  logic [rx_pkg::IDX_W-1:0]        bit_idx_q;
  logic [rx_pkg::DATA_BITS-1:0]    shift_q;
  logic                            bit_due;
  logic                            stop_sample;
  logic                            hold_free;

  assign bit_due     = (tick_q == (rx_pkg::TICK_W)'(rx_pkg::BIT_TICKS));
  assign stop_sample = (state_q == S_STOP) && bit_due;
  // A take in the same cycle frees the hold for the new byte
  assign hold_free   = !hold_valid || hold_take;

  // ----------------------------------------
  // Frame state machine
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= S_IDLE;
      tick_q    <= '0;
      bit_idx_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          tick_q    <= '0;
          bit_idx_q <= '0;
          if (enable && line.fall) begin
            state_q <= S_START;
            tick_q  <= (rx_pkg::TICK_W)'(1);
          end
        end
        S_START: begin
          tick_q <= tick_q + 1'b1;
          // Mid start bit, line must still be low
          if (tick_q == (rx_pkg::TICK_W)'(rx_pkg::HALF_TICKS)) begin
            tick_q  <= (rx_pkg::TICK_W)'(1);
            state_q <= line.level ? S_IDLE : S_DATA;
          end
        end
        S_DATA: begin
          tick_q <= tick_q + 1'b1;
          if (bit_due) begin
            tick_q    <= (rx_pkg::TICK_W)'(1);
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == (rx_pkg::IDX_W)'(rx_pkg::DATA_BITS - 1)) begin
              state_q <= S_STOP;
            end
          end
        end
        S_STOP: begin
          tick_q <= tick_q + 1'b1;
          // Back to idle right away, rest of stop bit can hold a new start
          if (bit_due) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state_q == S_DATA && bit_due) begin
      shift_q[bit_idx_q] <= line.level;
    end
    if (stop_sample && hold_free) begin
      hold_byte.data      <= shift_q;
      hold_byte.frame_err <= !line.level;
    end
  end

  // ----------------------------------------
  // Holding register and overrun
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
      overrun    <= 1'b0;
    end else begin
      if (stop_sample && hold_free) begin
        hold_valid <= 1'b1;
      end else if (hold_take) begin
        hold_valid <= 1'b0;
      end
      // New byte is dropped, old one stays in the hold
      if (stop_sample && !hold_free) begin
        overrun <= 1'b1;
      end else if (overrun_clr) begin
        overrun <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: rx_collector.sv
`timescale 1ns/100ps
`default_nettype none

module rx_collector (
  input  wire logic                                     clk,
  input  wire logic                                     rst_n,
  input  wire logic         [rx_pkg::NUM_LANES-1:0]     hold_valid,
  input  rx_pkg::rx_byte_t  [rx_pkg::NUM_LANES-1:0]     hold_bytes,
  input  wire logic                                     pop,
  output logic              [rx_pkg::NUM_LANES-1:0]     hold_take,
  output rx_pkg::rx_entry_t                             head,
  output logic              [rx_pkg::CNT_W-1:0]         count
);

  rx_pkg::rx_entry_t          mem_q [rx_pkg::FIFO_DEPTH];
  logic [rx_pkg::FIFO_AW-1:0] wr_ptr_q;
  logic [rx_pkg::FIFO_AW-1:0] rd_ptr_q;
  rx_pkg::lane_idx_t          rr_q;
  rx_pkg::lane_idx_t          cand;
  rx_pkg::lane_idx_t          grant_lane;
  rx_pkg::rx_entry_t          wr_entry;
  logic                       grant_found;
  logic                       can_grant;
  logic                       empty;
  logic                       full;
  logic                       push;
  logic                       do_pop;

  assign empty  = (count == '0);
  assign full   = (count == (rx_pkg::CNT_W)'(rx_pkg::FIFO_DEPTH));
  assign push   = |hold_take;
  assign do_pop = pop && !empty;
  // No grant while a take is in flight, so full never gets overshot
  assign can_grant = !full && !push;

  // ----------------------------------------
  // Round-robin arbiter
  // ----------------------------------------
  always_comb begin
    grant_found = 1'b0;
    grant_lane  = rr_q;
    cand        = rr_q;
    for (int i = 1; i <= rx_pkg::NUM_LANES; i++) begin
      cand = rx_pkg::lane_idx_t'(rr_q + i);
      if (!grant_found && hold_valid[cand]) begin
        grant_found = 1'b1;
        grant_lane  = cand;
      end
    end
  end

  // rr_q doubles as the lane being taken in the take cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_take <= '0;
      rr_q      <= rx_pkg::lane_idx_t'(rx_pkg::NUM_LANES - 1);
    end else begin
      hold_take <= '0;
      if (can_grant && grant_found) begin
        hold_take[grant_lane] <= 1'b1;
        rr_q                  <= grant_lane;
      end
    end
  end

  // ----------------------------------------
  // Receive FIFO
  // ----------------------------------------
  assign wr_entry = '{valid: 1'b1, lane: rr_q, rx: hold_bytes[rr_q]};

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_entry;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head = empty ? '0 : mem_q[rd_ptr_q];

endmodule

`default_nettype wire

// File: rx_wb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module rx_wb_regs (
  input  wire logic                                 clk,
  input  wire logic                                 rst_n,
  input  rx_pkg::wb_req_t                           wb_req,
  input  rx_pkg::rx_entry_t                         head,
  input  wire logic          [rx_pkg::CNT_W-1:0]    count,
  input  wire logic          [rx_pkg::NUM_LANES-1:0] overrun,
  output rx_pkg::wb_rsp_t                           wb_rsp,
  output logic                                      pop,
  output logic               [rx_pkg::NUM_LANES-1:0] enable,
  output logic               [rx_pkg::NUM_LANES-1:0] overrun_clr
);

  logic                     sel;
  logic                     acc;
  logic                     ack_q;
  logic                     is_ctrl;
  logic                     is_status;
  logic                     is_rxdata;
  rx_pkg::rx_status_t       status;
  logic [rx_pkg::WB_DW-1:0] rdata;

  assign sel = wb_req.cyc && wb_req.stb;
  // Request is still held in the ack cycle, side effects happen there
  assign acc = ack_q && sel;

  assign is_ctrl   = (wb_req.adr == rx_pkg::ADDR_CTRL);
  assign is_status = (wb_req.adr == rx_pkg::ADDR_STATUS);
  assign is_rxdata = (wb_req.adr == rx_pkg::ADDR_RXDATA);

  // ----------------------------------------
  // Single-cycle ack and control register
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q  <= 1'b0;
      enable <= '0;
    end else begin
      ack_q <= sel && !ack_q;
      if (acc && wb_req.we && is_ctrl) begin
        enable <= wb_req.dat[rx_pkg::NUM_LANES-1:0];
      end
    end
  end

  assign pop         = acc && !wb_req.we && is_rxdata && head.valid;
  // Write-one-to-clear on STATUS
  assign overrun_clr = (acc && wb_req.we && is_status) ?
                       wb_req.dat[rx_pkg::NUM_LANES-1:0] : '0;

  assign status = '{count: count, overrun: overrun};

  // ----------------------------------------
  // Read data
  // ----------------------------------------
  always_comb begin
    rdata = '0;
    if (is_ctrl) begin
      rdata[rx_pkg::NUM_LANES-1:0] = enable;
    end else if (is_status) begin
      rdata[$bits(rx_pkg::rx_status_t)-1:0] = status;
    end else if (is_rxdata) begin
      // head is all zeros when the FIFO is empty
      rdata[$bits(rx_pkg::rx_entry_t)-1:0] = head;
    end
  end

  assign wb_rsp = '{ack: ack_q, dat: rdata};

endmodule

`default_nettype wire

// File: uart_rx_bank.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_bank (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic [rx_pkg::NUM_LANES-1:0]      rx_lines,
  input  rx_pkg::wb_req_t                        wb_req,
  output rx_pkg::wb_rsp_t                        wb_rsp
);

  rx_pkg::line_t    [rx_pkg::NUM_LANES-1:0] lines;
  rx_pkg::rx_byte_t [rx_pkg::NUM_LANES-1:0] hold_bytes;
  logic             [rx_pkg::NUM_LANES-1:0] hold_valid;
  logic             [rx_pkg::NUM_LANES-1:0] hold_take;
  logic             [rx_pkg::NUM_LANES-1:0] enable;
  logic             [rx_pkg::NUM_LANES-1:0] overrun;
  logic             [rx_pkg::NUM_LANES-1:0] overrun_clr;
  rx_pkg::rx_entry_t                        head;
  logic             [rx_pkg::CNT_W-1:0]     count;
  logic                                     pop;

  line_sync i_line_sync (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_lines (rx_lines),
    .lines    (lines)
  );

  // One receiver per serial line
  for (genvar i = 0; i < rx_pkg::NUM_LANES; i++) begin : g_lane
    uart_rx_lane i_lane (
      .clk         (clk),
      .rst_n       (rst_n),
      .line        (lines[i]),
      .enable      (enable[i]),
      .hold_take   (hold_take[i]),
      .overrun_clr (overrun_clr[i]),
      .hold_valid  (hold_valid[i]),
      .hold_byte   (hold_bytes[i]),
      .overrun     (overrun[i])
    );
  end

  rx_collector i_collector (
    .clk        (clk),
    .rst_n      (rst_n),
    .hold_valid (hold_valid),
    .hold_bytes (hold_bytes),
    .pop        (pop),
    .hold_take  (hold_take),
    .head       (head),
    .count      (count)
  );

  rx_wb_regs i_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_req      (wb_req),
    .head        (head),
    .count       (count),
    .overrun     (overrun),
    .wb_rsp      (wb_rsp),
    .pop         (pop),
    .enable      (enable),
    .overrun_clr (overrun_clr)
  );

endmodule

`default_nettype wire

// File: tb_uart_rx_bank.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uart_rx_bank;

  localparam int ACK_LIMIT  = 16;
  localparam int POLL_LIMIT = 400;

  logic                         clk;
  logic                         rst_n;
  logic [rx_pkg::NUM_LANES-1:0] rx_lines;
  rx_pkg::wb_req_t              wb_req;
  rx_pkg::wb_rsp_t              wb_rsp;

  integer            seed = 32'h03c6_eb4a;
  // Expected entries per lane, and entries read back from RXDATA
  rx_pkg::rx_entry_t exp_q [rx_pkg::NUM_LANES][$];
  rx_pkg::rx_entry_t got_q [$];

  uart_rx_bank i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_lines (rx_lines),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // Reference model and compare tasks
  // ----------------------------------------
  function automatic rx_pkg::rx_entry_t expected_entry(input int lane,
      input logic [rx_pkg::DATA_BITS-1:0] data, input logic stop_level);
    rx_pkg::rx_entry_t e;
    e.valid        = 1'b1;
    e.lane         = rx_pkg::lane_idx_t'(lane);
    e.rx.frame_err = !stop_level;
    e.rx.data      = data;
    return e;
  endfunction

  function automatic rx_pkg::rx_status_t status_of(input int count,
      input logic [rx_pkg::NUM_LANES-1:0] ovr);
    rx_pkg::rx_status_t s;
    s.count   = (rx_pkg::CNT_W)'(count);
    s.overrun = ovr;
    return s;
  endfunction

  task automatic end_with_failure();
    $display("Testbench failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_entry(input rx_pkg::rx_entry_t got, input rx_pkg::rx_entry_t exp,
      input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_status(input rx_pkg::rx_status_t got, input rx_pkg::rx_status_t exp,
      input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s got count %0d overrun %b expected count %0d overrun %b",
               $time, what, got.count, got.overrun, exp.count, exp.overrun);
      end_with_failure();
    end
  endtask

  task automatic check_ctrl(input logic [rx_pkg::NUM_LANES-1:0] got,
      input logic [rx_pkg::NUM_LANES-1:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  // ----------------------------------------
  // Wishbone host
  // ----------------------------------------
  task automatic bus_cycle(input logic we, input logic [rx_pkg::WB_AW-1:0] adr,
      input logic [rx_pkg::WB_DW-1:0] wdat, output logic [rx_pkg::WB_DW-1:0] rdat);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    @(negedge clk);
    while (!wb_rsp.ack) begin
      if (waited == ACK_LIMIT) begin
        $display("Timeout: no Wishbone ack within %0d cycles", ACK_LIMIT);
        end_with_failure();
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    // ack rises one clock after stb
    if (waited != 1) begin
      $display("ERROR %0t: ack came %0d cycles after stb, expected 1", $time, waited);
      end_with_failure();
    end
    rdat = wb_rsp.dat;
    // Request drops in the cycle after ack
    @(posedge clk);
    wb_req <= '0;
    @(negedge clk);
    if (wb_rsp.ack) begin
      $display("ERROR %0t: ack still high in the cycle after the access", $time);
      end_with_failure();
    end
  endtask

  task automatic wb_write(input logic [rx_pkg::WB_AW-1:0] adr,
      input logic [rx_pkg::WB_DW-1:0] dat);
    logic [rx_pkg::WB_DW-1:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [rx_pkg::WB_AW-1:0] adr,
      output logic [rx_pkg::WB_DW-1:0] dat);
    bus_cycle(1'b0, adr, '0, dat);
  endtask

  task automatic read_status(output rx_pkg::rx_status_t st);
    logic [rx_pkg::WB_DW-1:0] rd;
    wb_read(rx_pkg::ADDR_STATUS, rd);
    st = rd[$bits(rx_pkg::rx_status_t)-1:0];
  endtask

  // Polls STATUS until the FIFO holds at least target entries
  task automatic wait_for_count(input int target);
    rx_pkg::rx_status_t st;
    int polls;
    polls = 0;
    read_status(st);
    while (int'(st.count) < target) begin
      if (polls == POLL_LIMIT) begin
        $display("Timeout: FIFO count stuck at %0d while waiting for %0d", st.count, target);
        end_with_failure();
      end else begin
        polls++;
        repeat (8) @(posedge clk);
        read_status(st);
      end
    end
  endtask

  task automatic fetch_entry();
    logic [rx_pkg::WB_DW-1:0] rd;
    wait_for_count(1);
    wb_read(rx_pkg::ADDR_RXDATA, rd);
    got_q.push_back(rd[$bits(rx_pkg::rx_entry_t)-1:0]);
  endtask

  // ----------------------------------------
  // Serial line drivers
  // ----------------------------------------
  task automatic drive_bit(input int lane, input logic v);
    @(posedge clk);
    rx_lines[lane] <= v;
    repeat (rx_pkg::BIT_TICKS - 1) @(posedge clk);
  endtask

  task automatic send_frame(input int lane, input logic [rx_pkg::DATA_BITS-1:0] data,
      input logic stop_level, input logic expect_it);
    if (expect_it) begin
      exp_q[lane].push_back(expected_entry(lane, data, stop_level));
    end
    drive_bit(lane, 1'b0);
    for (int i = 0; i < rx_pkg::DATA_BITS; i++) begin
      drive_bit(lane, data[i]);
    end
    drive_bit(lane, stop_level);
    // Return to idle after a broken stop bit
    if (!stop_level) begin
      drive_bit(lane, 1'b1);
    end
  endtask

  // Only the first kept frames are expected to reach the FIFO
  task automatic send_burst(input int lane, input int frames, input int kept);
    logic [31:0] rnd;
    for (int f = 0; f < frames; f++) begin
      rnd = $random(seed);
      send_frame(lane, rnd[rx_pkg::DATA_BITS-1:0], 1'b1, f < kept);
    end
  endtask

  task automatic send_glitch(input int lane);
    @(posedge clk);
    rx_lines[lane] <= 1'b0;
    repeat (rx_pkg::HALF_TICKS / 2) @(posedge clk);
    rx_lines[lane] <= 1'b1;
    repeat (rx_pkg::BIT_TICKS) @(posedge clk);
  endtask

  // Each entry read back must match the oldest one expected on its lane
  initial begin : compare_proc
    rx_pkg::rx_entry_t got;
    forever begin
      @(posedge clk);
      while (got_q.size() != 0) begin
        got = got_q.pop_front();
        if (exp_q[got.lane].size() == 0) begin
          $display("ERROR %0t: unexpected entry %h read back for lane %0d",
                   $time, got, got.lane);
          end_with_failure();
        end else begin
          check_entry(got, exp_q[got.lane].pop_front(), "RXDATA entry");
        end
      end
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : main_proc
    rx_pkg::rx_status_t       st;
    logic [rx_pkg::WB_DW-1:0] rd;
    logic [31:0]              rnd;
    int                       leftover;
    rx_lines = '1;
    wb_req   = '0;
    rst_n    = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Reset values
    read_status(st);
    check_status(st, status_of(0, '0), "STATUS after reset");
    wb_read(rx_pkg::ADDR_CTRL, rd);
    check_ctrl(rd[rx_pkg::NUM_LANES-1:0], '0, "CTRL after reset");
    wb_read(rx_pkg::ADDR_RXDATA, rd);
    check_entry(rd[$bits(rx_pkg::rx_entry_t)-1:0], '0, "RXDATA with empty FIFO");

    // Single frame on lane 0
    wb_write(rx_pkg::ADDR_CTRL, 32'h1);
    wb_read(rx_pkg::ADDR_CTRL, rd);
    check_ctrl(rd[rx_pkg::NUM_LANES-1:0], 4'b0001, "CTRL readback");
    rnd = $random(seed);
    send_frame(0, rnd[rx_pkg::DATA_BITS-1:0], 1'b1, 1'b1);
    fetch_entry();

    // All lanes at once
    wb_write(rx_pkg::ADDR_CTRL, 32'hf);
    fork
      send_burst(0, 2, 2);
      send_burst(1, 2, 2);
      send_burst(2, 2, 2);
      send_burst(3, 2, 2);
    join
    wait_for_count(8);
    repeat (8) fetch_entry();

    // Low stop bit
    rnd = $random(seed);
    send_frame(2, rnd[rx_pkg::DATA_BITS-1:0], 1'b0, 1'b1);
    fetch_entry();

    // Disabled lane 3 and a short glitch on lane 0
    wb_write(rx_pkg::ADDR_CTRL, 32'h7);
    fork
      send_burst(3, 1, 0);
      send_glitch(0);
    join
    repeat (2 * rx_pkg::BIT_TICKS) @(posedge clk);
    read_status(st);
    check_status(st, status_of(0, '0), "STATUS after ignored traffic");

    // Overrun on lane 1 where the tenth byte is lost
    wb_write(rx_pkg::ADDR_CTRL, 32'hf);
    send_burst(1, 10, 9);
    wait_for_count(8);
    read_status(st);
    check_status(st, status_of(8, 4'b0010), "STATUS with lane 1 overrun");
    wb_write(rx_pkg::ADDR_STATUS, 32'h2);
    read_status(st);
    check_status(st, status_of(8, '0), "STATUS after overrun clear");
    repeat (9) fetch_entry();

    repeat (4) @(posedge clk);
    read_status(st);
    check_status(st, status_of(0, '0), "STATUS after draining");
    wb_read(rx_pkg::ADDR_RXDATA, rd);
    check_entry(rd[$bits(rx_pkg::rx_entry_t)-1:0], '0, "RXDATA after draining");
    repeat (2) @(posedge clk);
    leftover = got_q.size();
    for (int l = 0; l < rx_pkg::NUM_LANES; l++) begin
      leftover += exp_q[l].size();
    end
    if (leftover != 0) begin
      $display("Run ended with %0d expected entries that never arrived", leftover);
      end_with_failure();
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: flist.f
rx_pkg.sv
line_sync.sv
uart_rx_lane.sv
rx_collector.sv
rx_wb_regs.sv
uart_rx_bank.sv
tb_uart_rx_bank.sv

// File: Bender.yml
package:
  name: uart_rx_bank

sources:
  - rx_pkg.sv
  - line_sync.sv
  - uart_rx_lane.sv
  - rx_collector.sv
  - rx_wb_regs.sv
  - uart_rx_bank.sv
  - target: simulation
    files:
      - tb_uart_rx_bank.sv
